//--- fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	////////////////////////////////////////////////////////////
	// instruction side
	////////////////////////////////////////////////////////////

	// rv32 instruction width
	localparam int XLEN = 32;

	// one instruction word as stored and as handed downstream
	typedef logic [XLEN-1:0] instr_t;

	// byte program counter covering 4 KiB of code
	localparam int PC_W = 12;
	typedef logic [PC_W-1:0] pc_t;

	////////////////////////////////////////////////////////////
	// memory side
	////////////////////////////////////////////////////////////

	// word address drops the two byte-offset bits of the pc
	localparam int IMEM_ADDR_W = PC_W - 2;
	typedef logic [IMEM_ADDR_W-1:0] imem_addr_t;

endpackage

`default_nettype wire

//--- loader_pkg.sv
`default_nettype none

package loader_pkg;

	// 8n1 frame with lsb sent first
	localparam int UART_DATA_BITS = 8;

	// bytes arrive least significant first
	localparam int BYTES_PER_WORD = 4;

	// receiver walk through one frame
	typedef enum logic [1:0] {
		uart_idle,
		uart_start,
		uart_data,
		uart_stop
	} uart_state_e;

	// loader only leaves idle while prog is high
	typedef enum logic [1:0] {
		ld_idle,
		ld_collect,
		ld_write
	} loader_state_e;

endpackage

`default_nettype wire

//--- imem_port_if.sv
`default_nettype none

interface imem_port_if;

	// request half, driven by whoever wants the ram
	logic                  req;
	logic                  we;
	fetch_pkg::imem_addr_t addr;
	fetch_pkg::instr_t     wdata;

	// response half
	logic                  gnt;
	fetch_pkg::instr_t     rdata;

	modport requester (
		output req, we, addr, wdata,
		input  gnt, rdata
	);

	modport arbiter_side (
		input  req, we, addr, wdata,
		output gnt, rdata
	);

	// ram accepts every request so it raises no grant
	modport memory (
		input  req, we, addr, wdata,
		output rdata
	);

endinterface

`default_nettype wire

//--- uart_rx.sv
`default_nettype none

module uart_rx #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic                                  bus,
	input  logic                                  rst_n,
	input  logic                                  rx,
	output logic                                  byte_valid,
	output logic [loader_pkg::UART_DATA_BITS-1:0] byte_data
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam int IDX_W = $clog2(loader_pkg::UART_DATA_BITS);
	// half a bit lands the sampling point mid-bit
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(loader_pkg::UART_DATA_BITS - 1);

	loader_pkg::uart_state_e               state;
	logic                                  rx_meta;
	logic                                  rx_sync;
	logic [CNT_W-1:0]                      clk_cnt;
	logic [IDX_W-1:0]                      bit_idx;
	logic [loader_pkg::UART_DATA_BITS-1:0] shift;

	// two-flop synchronizer, line idles high
	always_ff @(posedge bus) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	////////////////////////////////////////////////////////////
	// frame fsm
	////////////////////////////////////////////////////////////

	always_ff @(posedge bus) begin
		if (!rst_n) begin
			state      <= loader_pkg::uart_idle;
			clk_cnt    <= '0;
			bit_idx    <= '0;
			byte_valid <= 1'b0;
		end else begin
			// strobe lasts one cycle
			byte_valid <= 1'b0;
			case (state)
				loader_pkg::uart_idle: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					// falling edge opens a frame
					if (!rx_sync) begin
						state <= loader_pkg::uart_start;
					end
				end
				loader_pkg::uart_start: begin
					if (clk_cnt == HALF_BIT) begin
						clk_cnt <= '0;
						// glitch shorter than half a bit goes back to idle
						state   <= rx_sync ? loader_pkg::uart_idle : loader_pkg::uart_data;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				loader_pkg::uart_data: begin
					if (clk_cnt == FULL_BIT) begin
						clk_cnt <= '0;
						// lsb first so shift in from the top
						shift   <= {rx_sync, shift[loader_pkg::UART_DATA_BITS-1:1]};
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == LAST_BIT) begin
							state <= loader_pkg::uart_stop;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				loader_pkg::uart_stop: begin
					if (clk_cnt == FULL_BIT) begin
						clk_cnt <= '0;
						state   <= loader_pkg::uart_idle;
						// framing error drops the byte
						if (rx_sync) begin
							byte_valid <= 1'b1;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= loader_pkg::uart_idle;
			endcase
		end
	end

	// shift register is stable through the stop bit
	assign byte_data = shift;

endmodule

`default_nettype wire

//--- prog_loader.sv
`default_nettype none

module prog_loader #(
	parameter int IMEM_WORDS = 256
) (
	input  logic                                  bus,
	input  logic                                  rst_n,
	input  logic                                  prog,
	input  logic                                  byte_valid,
	input  logic [loader_pkg::UART_DATA_BITS-1:0] byte_data,
	imem_port_if.requester                        mem
);

	localparam int BCNT_W = $clog2(loader_pkg::BYTES_PER_WORD);
	localparam logic [BCNT_W-1:0] LAST_BYTE = BCNT_W'(loader_pkg::BYTES_PER_WORD - 1);
	localparam fetch_pkg::imem_addr_t LAST_WORD = fetch_pkg::IMEM_ADDR_W'(IMEM_WORDS - 1);

	loader_pkg::loader_state_e state;
	logic [BCNT_W-1:0]         byte_cnt;
	fetch_pkg::imem_addr_t     word_cnt;
	fetch_pkg::instr_t         word;
	logic                      take_byte;
	logic                      write_req;

	// bytes only count while collecting under prog
	assign take_byte = (state == loader_pkg::ld_collect) & prog & byte_valid;
	assign write_req = (state == loader_pkg::ld_write);

	// write only, never reads back
	assign mem.req   = write_req;
	assign mem.we    = write_req;
	assign mem.addr  = word_cnt;
	assign mem.wdata = word;

	always_ff @(posedge bus) begin
		if (!rst_n) begin
			state    <= loader_pkg::ld_idle;
			byte_cnt <= '0;
			word_cnt <= '0;
		end else begin
			case (state)
				loader_pkg::ld_idle: begin
					// rise of prog restarts the image at word 0
					byte_cnt <= '0;
					word_cnt <= '0;
					if (prog) begin
						state <= loader_pkg::ld_collect;
					end
				end
				loader_pkg::ld_collect: begin
					if (!prog) begin
						state <= loader_pkg::ld_idle;
					end else if (take_byte) begin
						byte_cnt <= (byte_cnt == LAST_BYTE) ? '0 : byte_cnt + 1'b1;
						if (byte_cnt == LAST_BYTE) begin
							state <= loader_pkg::ld_write;
						end
					end
				end
				loader_pkg::ld_write: begin
					// loader has priority so gnt comes in this cycle
					if (mem.gnt) begin
						word_cnt <= (word_cnt == LAST_WORD) ? '0 : word_cnt + 1'b1;
						state    <= prog ? loader_pkg::ld_collect : loader_pkg::ld_idle;
					end
				end
				default: state <= loader_pkg::ld_idle;
			endcase
		end
	end

	// first byte ends up in bits 7:0
	always_ff @(posedge bus) begin
		if (take_byte) begin
			word <= {byte_data, word[fetch_pkg::XLEN-1:loader_pkg::UART_DATA_BITS]};
		end
	end

endmodule

`default_nettype wire

//--- imem_arbiter.sv
`default_nettype none

module imem_arbiter (
	input  logic              bus,
	input  logic              rst_n,
	imem_port_if.arbiter_side loader,
	imem_port_if.arbiter_side fetch,
	imem_port_if.requester    mem
);

	logic loader_gnt;
	logic fetch_gnt;

	////////////////////////////////////////////////////////////
	// fixed priority, loader over fetch
	////////////////////////////////////////////////////////////

	assign loader_gnt = loader.req;
	assign fetch_gnt  = fetch.req & ~loader.req;

	assign loader.gnt = loader_gnt;
	assign fetch.gnt  = fetch_gnt;

	// winner drives the ram port
	assign mem.req   = loader.req | fetch.req;
	assign mem.we    = loader_gnt ? loader.we : fetch.we;
	assign mem.addr  = loader_gnt ? loader.addr : fetch.addr;
	assign mem.wdata = loader_gnt ? loader.wdata : fetch.wdata;

	////////////////////////////////////////////////////////////
	// read data
	////////////////////////////////////////////////////////////

	// same ram output on both ports
	// each requester knows which read is its own
	assign loader.rdata = mem.rdata;
	assign fetch.rdata  = mem.rdata;

endmodule

`default_nettype wire

//--- instr_mem.sv
`default_nettype none

module instr_mem #(
	parameter int IMEM_WORDS = 256
) (
	input logic         bus,
	imem_port_if.memory port
);

	// only the low bits index a smaller ram
	localparam int AW = $clog2(IMEM_WORDS);

	fetch_pkg::instr_t ram [IMEM_WORDS];

	// single port, req acts as enable
	always_ff @(posedge bus) begin
		if (port.req) begin
			if (port.we) begin
				ram[port.addr[AW-1:0]] <= port.wdata;
			end else begin
				// read data out one edge later
				port.rdata <= ram[port.addr[AW-1:0]];
			end
		end
	end

endmodule

`default_nettype wire

//--- fetch_unit.sv
`default_nettype none

module fetch_unit #(
	parameter int CREDITS = 4
) (
	input  logic              bus,
	input  logic              rst_n,
	input  logic              prog,
	input  logic              redirect_valid,
	input  fetch_pkg::pc_t    redirect_pc,
	input  logic              credit_return,
	imem_port_if.requester    mem,
	output logic              ins_valid,
	output fetch_pkg::instr_t ins,
	output fetch_pkg::pc_t    ins_pc
);

	localparam int CRED_W = $clog2(CREDITS + 1);

	fetch_pkg::pc_t    pc;
	logic [CRED_W-1:0] credits;
	// low for the reset cycles, keeps req quiet out of reset
	logic              run;
	logic              epoch;
	logic              pending;
	logic              pend_epoch;
	fetch_pkg::pc_t    pend_pc;
	logic              issue;
	logic              live;
	logic              refund;

	////////////////////////////////////////////////////////////
	// request side
	////////////////////////////////////////////////////////////

	// read the word under pc while a credit is left
	assign mem.req   = run & ~prog & (credits != '0);
	assign mem.we    = 1'b0;
	assign mem.addr  = pc[fetch_pkg::PC_W-1:2];
	assign mem.wdata = '0;

	assign issue = mem.req & mem.gnt;

	// returning word survives only on the current path
	assign live   = pending & (pend_epoch == epoch) & ~redirect_valid & ~prog;
	// dropped read hands its credit back
	assign refund = pending & ~live;

	always_ff @(posedge bus) begin
		if (!rst_n) begin
			run       <= 1'b0;
			pc        <= '0;
			credits   <= CRED_W'(CREDITS);
			epoch     <= 1'b0;
			pending   <= 1'b0;
			ins_valid <= 1'b0;
		end else begin
			run       <= 1'b1;
			credits   <= credits - CRED_W'(issue) + CRED_W'(credit_return) + CRED_W'(refund);
			pending   <= issue;
			ins_valid <= live;
			// programming mode pins pc to 0
			if (prog) begin
				pc <= '0;
			end else if (redirect_valid) begin
				// new path, a read issued now carries the old epoch
				pc    <= redirect_pc;
				epoch <= ~epoch;
			end else if (issue) begin
				pc <= pc + fetch_pkg::PC_W'(4);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// payload
	////////////////////////////////////////////////////////////

	always_ff @(posedge bus) begin
		// tag the read with its path and address
		if (issue) begin
			pend_epoch <= epoch;
			pend_pc    <= pc;
		end
		if (live) begin
			ins    <= mem.rdata;
			ins_pc <= pend_pc;
		end
	end

endmodule

`default_nettype wire

//--- fetch_top.sv
`default_nettype none

module fetch_top #(
	parameter int CLKS_PER_BIT = 8,
	parameter int CREDITS      = 4,
	// quarter of the addressable words by default
	parameter int IMEM_WORDS   = 2 ** (fetch_pkg::IMEM_ADDR_W - 2)
) (
	input  logic              bus,
	input  logic              rst_n,
	input  logic              rx,
	input  logic              prog,
	input  logic              redirect_valid,
	input  fetch_pkg::pc_t    redirect_pc,
	input  logic              credit_return,
	output logic              ins_valid,
	output fetch_pkg::instr_t ins,
	output fetch_pkg::pc_t    ins_pc
);

	logic                                  byte_valid;
	logic [loader_pkg::UART_DATA_BITS-1:0] byte_data;

	// one port per requester plus the ram side
	imem_port_if loader_port ();
	imem_port_if fetch_port ();
	imem_port_if mem_port ();

	////////////////////////////////////////////////////////////
	// serial load path
	////////////////////////////////////////////////////////////

	uart_rx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) i_uart_rx (
		.bus        (bus),
		.rst_n      (rst_n),
		.rx         (rx),
		.byte_valid (byte_valid),
		.byte_data  (byte_data)
	);

	prog_loader #(
		.IMEM_WORDS(IMEM_WORDS)
	) i_prog_loader (
		.bus        (bus),
		.rst_n      (rst_n),
		.prog       (prog),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.mem        (loader_port)
	);

	////////////////////////////////////////////////////////////
	// fetch path and shared ram
	////////////////////////////////////////////////////////////

	fetch_unit #(
		.CREDITS(CREDITS)
	) i_fetch_unit (
		.bus            (bus),
		.rst_n          (rst_n),
		.prog           (prog),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.credit_return  (credit_return),
		.mem            (fetch_port),
		.ins_valid      (ins_valid),
		.ins            (ins),
		.ins_pc         (ins_pc)
	);

	imem_arbiter i_imem_arbiter (
		.bus    (bus),
		.rst_n  (rst_n),
		.loader (loader_port),
		.fetch  (fetch_port),
		.mem    (mem_port)
	);

	instr_mem #(
		.IMEM_WORDS(IMEM_WORDS)
	) i_instr_mem (
		.bus  (bus),
		.port (mem_port)
	);

endmodule

`default_nettype wire

//--- tb_fetch_top.sv
`default_nettype none

module tb_fetch_top;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int          CLKS_PER_BIT = 8;
	localparam int          CREDITS      = 4;
	localparam int          IMEM_WORDS   = 256;
	localparam logic [31:0] SEED         = 32'h8e1f_079b;
	localparam int          MAX_ROWS     = 32;
	// first program plus the reload
	localparam int          N_WORDS      = 12;
	// quiet window where no output may appear
	localparam int          SETTLE       = 12;

	typedef enum int {
		act_load,
		act_take,
		act_hold,
		act_release,
		act_redirect,
		act_prog
	} act_e;

	logic              bus;
	logic              rst_n;
	logic              rx;
	logic              prog;
	logic              redirect_valid;
	fetch_pkg::pc_t    redirect_pc;
	logic              credit_return;
	logic              ins_valid;
	fetch_pkg::instr_t ins;
	fetch_pkg::pc_t    ins_pc;

	// stimulus table, one entry per row index
	string             row_name    [MAX_ROWS];
	act_e              row_act     [MAX_ROWS];
	int                row_arg     [MAX_ROWS];
	fetch_pkg::pc_t    row_pc      [MAX_ROWS];
	fetch_pkg::instr_t row_ins     [MAX_ROWS];
	bit                row_has_ins [MAX_ROWS];
	int                n_rows;

	// reference model of memory and pc
	fetch_pkg::instr_t words        [N_WORDS];
	fetch_pkg::instr_t model_mem    [IMEM_WORDS];
	bit                model_loaded [IMEM_WORDS];
	fetch_pkg::pc_t    model_pc;
	int                model_src;

	// outputs seen but not yet consumed
	fetch_pkg::pc_t    got_pc  [$];
	fetch_pkg::instr_t got_ins [$];

	// credit model, consumed outputs not yet handed back
	int                owed;
	bit                hold;
	bit                grant_one;

	int                load_src;
	int                cycles = 0;
	int                limit;
	int                pass_count;
	int                fail_count;
	bit                row_ok;
	string             cur_name;

	initial begin
		bus = 1'b0;
		forever begin
			#2 bus = ~bus;
		end
	end

	fetch_top #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.CREDITS     (CREDITS),
		.IMEM_WORDS  (IMEM_WORDS)
	) i_dut (
		.bus            (bus),
		.rst_n          (rst_n),
		.rx             (rx),
		.prog           (prog),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.credit_return  (credit_return),
		.ins_valid      (ins_valid),
		.ins            (ins),
		.ins_pc         (ins_pc)
	);

	// outputs are stable mid-cycle
	always @(negedge bus) begin
		if (ins_valid) begin
			got_pc.push_back(ins_pc);
			got_ins.push_back(ins);
		end
	end

	// watchdog
	always @(posedge bus) begin
		cycles = cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("timeout after %0d cycles, stuck in test %s", cycles, cur_name);
			$display("Finished with errors");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// table and model
	////////////////////////////////////////////////////////////

	task automatic add_row(input string name, input act_e act, input int arg);
		int idx;
		int i;
		idx = int'(model_pc[fetch_pkg::PC_W-1:2]) % IMEM_WORDS;
		row_name[n_rows]    = name;
		row_act[n_rows]     = act;
		row_arg[n_rows]     = arg;
		row_pc[n_rows]      = model_pc;
		row_ins[n_rows]     = model_mem[idx];
		row_has_ins[n_rows] = model_loaded[idx];
		case (act)
			act_load: begin
				// image lands at word 0, fetch restarts at 0
				for (i = 0; i < arg; i++) begin
					model_mem[i]    = words[model_src + i];
					model_loaded[i] = 1'b1;
				end
				model_src = model_src + arg;
				model_pc  = '0;
			end
			act_take, act_release: model_pc = model_pc + 12'd4;
			act_hold:              model_pc = model_pc + fetch_pkg::pc_t'(4 * arg);
			act_redirect:          model_pc = fetch_pkg::pc_t'(arg);
			act_prog:              model_pc = '0;
			default:               model_pc = model_pc;
		endcase
		n_rows = n_rows + 1;
	endtask

	task automatic build_table();
		int i;
		add_row("reset_credit_limit", act_hold, CREDITS);
		add_row("load_8_words", act_load, 8);
		for (i = 0; i < 8; i++) begin
			add_row($sformatf("fetch_pc_%0d", 4 * i), act_take, 0);
		end
		add_row("withhold_credits", act_hold, CREDITS);
		add_row("return_one_credit", act_release, 1);
		add_row("redirect_to_16", act_redirect, 16);
		for (i = 0; i < 4; i++) begin
			add_row($sformatf("redirect_pc_%0d", 16 + 4 * i), act_take, 0);
		end
		add_row("reassert_prog", act_prog, SETTLE);
		add_row("load_4_words", act_load, 4);
		// words 4 and 5 keep the first image
		for (i = 0; i < 6; i++) begin
			add_row($sformatf("reload_pc_%0d", 4 * i), act_take, 0);
		end
	endtask

	// serial time of every loaded byte plus a budget per fetch row, doubled
	function automatic int timeout_limit();
		int bytes;
		int fetch_rows;
		int r;
		bytes      = 0;
		fetch_rows = 0;
		for (r = 0; r < n_rows; r++) begin
			if (row_act[r] == act_load) begin
				bytes = bytes + row_arg[r] * loader_pkg::BYTES_PER_WORD;
			end else begin
				fetch_rows = fetch_rows + 1;
			end
		end
		return 2 * (bytes * 10 * CLKS_PER_BIT + 20 * fetch_rows);
	endfunction

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////

	// one clock, handing back a credit when one is owed
	task automatic tick();
		@(posedge bus);
		if (grant_one || (!hold && owed > 0)) begin
			credit_return <= 1'b1;
			owed      = owed - 1;
			grant_one = 1'b0;
		end else begin
			credit_return <= 1'b0;
		end
	endtask

	// consumer drops queued outputs but still returns their credits
	task automatic flush_outputs();
		owed = owed + got_pc.size();
		got_pc.delete();
		got_ins.delete();
	endtask

	task automatic raise_prog();
		tick();
		prog <= 1'b1;
		tick();
		flush_outputs();
	endtask

	task automatic drive_bit(input logic value);
		tick();
		rx <= value;
		repeat (CLKS_PER_BIT - 1) begin
			tick();
		end
	endtask

	// 8n1, lsb first
	task automatic send_byte(input logic [7:0] data);
		int i;
		drive_bit(1'b0);
		for (i = 0; i < 8; i++) begin
			drive_bit(data[i]);
		end
		drive_bit(1'b1);
	endtask

	task automatic wait_outputs(input int n);
		while (got_pc.size() < n) begin
			tick();
		end
	endtask

	task automatic compare_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %s %s: expected 0x%08h, actual 0x%08h",
				cur_name, what, expected, actual);
			row_ok = 1'b0;
		end
	endtask

	////////////////////////////////////////////////////////////
	// row runner
	////////////////////////////////////////////////////////////

	task automatic run_row(input int r);
		int i;
		int j;
		fetch_pkg::instr_t w;
		cur_name = row_name[r];
		row_ok   = 1'b1;
		case (row_act[r])
			act_load: begin
				hold = 1'b0;
				raise_prog();
				for (i = 0; i < row_arg[r]; i++) begin
					w = words[load_src + i];
					for (j = 0; j < loader_pkg::BYTES_PER_WORD; j++) begin
						send_byte(w[8 * j +: 8]);
					end
				end
				load_src = load_src + row_arg[r];
				// let the last write land
				repeat (2 * CLKS_PER_BIT) begin
					tick();
				end
				prog <= 1'b0;
			end
			act_take: begin
				wait_outputs(1);
				compare_value("ins_pc", 32'(row_pc[r]), 32'(got_pc[0]));
				if (row_has_ins[r]) begin
					compare_value("ins", row_ins[r], got_ins[0]);
				end
				void'(got_pc.pop_front());
				void'(got_ins.pop_front());
				owed = owed + 1;
			end
			act_hold: begin
				// settle the credit loop before starving it
				while (owed > 0) begin
					tick();
				end
				hold = 1'b1;
				wait_outputs(row_arg[r]);
				repeat (SETTLE) begin
					tick();
				end
				compare_value("outputs", 32'(row_arg[r]), 32'(got_pc.size()));
				for (i = 0; i < got_pc.size(); i++) begin
					compare_value("ins_pc", 32'(row_pc[r]) + 32'(4 * i), 32'(got_pc[i]));
				end
				flush_outputs();
			end
			act_release: begin
				grant_one = 1'b1;
				tick();
				wait_outputs(1);
				repeat (SETTLE) begin
					tick();
				end
				compare_value("outputs", 32'd1, 32'(got_pc.size()));
				compare_value("ins_pc", 32'(row_pc[r]), 32'(got_pc[0]));
				flush_outputs();
				hold = 1'b0;
			end
			act_redirect: begin
				// redirect while the stream runs
				wait_outputs(1);
				tick();
				redirect_valid <= 1'b1;
				redirect_pc    <= fetch_pkg::pc_t'(row_arg[r]);
				tick();
				redirect_valid <= 1'b0;
				flush_outputs();
			end
			act_prog: begin
				raise_prog();
				repeat (row_arg[r]) begin
					tick();
				end
				compare_value("outputs", 32'd0, 32'(got_pc.size()));
				flush_outputs();
			end
			default: row_ok = 1'b0;
		endcase
		if (row_ok) begin
			pass_count = pass_count + 1;
			$display("[PASS] %s", cur_name);
		end else begin
			fail_count = fail_count + 1;
			$display("[FAIL] %s", cur_name);
		end
	endtask

	initial begin
		int r;
		int i;
		rst_n          = 1'b0;
		rx             = 1'b1;
		prog           = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc    = '0;
		credit_return  = 1'b0;
		owed       = 0;
		hold       = 1'b0;
		grant_one  = 1'b0;
		n_rows     = 0;
		model_pc   = '0;
		model_src  = 0;
		load_src   = 0;
		limit      = 0;
		pass_count = 0;
		fail_count = 0;
		cur_name   = "reset";
		for (i = 0; i < IMEM_WORDS; i++) begin
			model_loaded[i] = 1'b0;
		end
		void'($urandom(SEED));
		for (i = 0; i < N_WORDS; i++) begin
			words[i] = $urandom();
		end
		build_table();
		limit = timeout_limit();
		repeat (2) begin
			@(posedge bus);
		end
		rst_n <= 1'b1;
		for (r = 0; r < n_rows; r++) begin
			run_row(r);
		end
		$display("tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- fetch_top.f
fetch_pkg.sv
loader_pkg.sv
imem_port_if.sv
uart_rx.sv
prog_loader.sv
imem_arbiter.sv
instr_mem.sv
fetch_unit.sv
fetch_top.sv
tb_fetch_top.sv

//--- Bender.yml
package:
  name: fetch_top

sources:
  - fetch_pkg.sv
  - loader_pkg.sv
  - imem_port_if.sv
  - uart_rx.sv
  - prog_loader.sv
  - imem_arbiter.sv
  - instr_mem.sv
  - fetch_unit.sv
  - fetch_top.sv
  - target: simulation
    files:
      - tb_fetch_top.sv
